// ==== sim.f ====
micro_pkg.sv
control_store.sv
opcode_queue.sv
micro_sequencer.sv
control_top.sv
control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the control section testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module control_tb -f sim.f

sim_output=$(./obj_dir/Vcontrol_tb 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -qF "Finished with no errors"; then
    exit 0
else
    exit 1
fi

// ==== control_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the control section: stimulus, reference
// microaddress model and concurrent checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module control_tb;

    localparam int queue_depth    = 4;
    localparam int timeout_cycles = 3000;

    logic        system_clk;
    logic        reset;
    logic [3:0]  opcode_in;
    logic        opcode_push;
    logic        go_bar;
    logic [3:0]  status_bits;
    logic        jam;
    logic [7:0]  microaddress;
    logic [10:0] control_bits;
    logic        eil_bar;
    logic        overflow;

    integer      seed;
    logic [31:0] rnd;
    int          cycle_count = 0;

    // Reference model state
    logic [7:0]  ref_addr;
    logic        ref_overflow;
    logic [3:0]  ref_queue [$];
    logic [7:0]  exp_addr;
    logic [10:0] exp_control;
    logic        exp_eil_bar;

    control_top #(
        .QUEUE_DEPTH(queue_depth)
    ) UUT (
        .system_clk   (system_clk),
        .reset        (reset),
        .opcode_in    (opcode_in),
        .opcode_push  (opcode_push),
        .go_bar       (go_bar),
        .status_bits  (status_bits),
        .jam          (jam),
        .microaddress (microaddress),
        .control_bits (control_bits),
        .eil_bar      (eil_bar),
        .overflow     (overflow)
    );

    initial begin
        system_clk = 1'b0;
        forever #4 system_clk = ~system_clk;
    end

    // Next microaddress as the microprogram is written
    function automatic logic [7:0] next_address(input logic [7:0] addr, input logic [3:0] head,
                                                input logic has_op, input logic go,
                                                input logic status2);
        if (addr == 8'h00) begin
            return go ? 8'h00 : 8'h01;
        end else if (addr == 8'h01) begin
            return has_op ? 8'h02 : 8'h01;
        end else if (addr == 8'h02) begin
            return {head, 4'h8};
        end
        case (addr[3:0])
            4'h8:    return {addr[7:4], 4'h9};
            4'h9:    return status2 ? {addr[7:4], 4'hC} : {addr[7:4], 4'hA};
            4'hA:    return 8'h00;
            4'hC:    return 8'h00;
            // Empty words branch home on status2, else hold
            default: return status2 ? 8'h00 : addr;
        endcase
    endfunction

    function automatic logic [10:0] control_for(input logic [7:0] addr);
        case (addr[3:0])
            4'h8:    return {addr[7:4], 7'b0000001};
            4'hA:    return {addr[7:4], 7'b0000100};
            4'hC:    return {addr[7:4], 7'b0000010};
            default: return 11'h000;
        endcase
    endfunction

    always @(posedge system_clk) begin : ref_model
        int         size_before;
        logic [3:0] head_op;
        if (reset) begin
            ref_addr     <= 8'h00;
            ref_overflow <= 1'b0;
            ref_queue.delete();
        end else begin
            size_before = ref_queue.size();
            head_op     = (size_before != 0) ? ref_queue[0] : 4'h0;
            ref_addr <= next_address(ref_addr, head_op, size_before != 0, go_bar,
                                     status_bits[2]);
            // Pop before push, full test on the occupancy before the edge
            if (ref_addr == 8'h02 && size_before != 0) begin
                void'(ref_queue.pop_front());
            end
            if (opcode_push) begin
                if (size_before < queue_depth) begin
                    ref_queue.push_back(opcode_in);
                end else begin
                    ref_overflow <= 1'b1;
                end
            end
        end
    end

    assign exp_addr    = jam ? 8'hFF : ref_addr;
    assign exp_control = jam ? 11'h000 : control_for(ref_addr);
    assign exp_eil_bar = (ref_addr != 8'h02);

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [10:0] expected,
                                  input logic [10:0] actual);
        $display("ERROR at time %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        stop_with_failure();
    endtask

    addr_check: assert property (@(posedge system_clk) disable iff (reset)
        microaddress == exp_addr)
        else value_mismatch("microaddress", {3'b0, $sampled(exp_addr)},
                            {3'b0, $sampled(microaddress)});

    control_check: assert property (@(posedge system_clk) disable iff (reset)
        control_bits == exp_control)
        else value_mismatch("control_bits", $sampled(exp_control), $sampled(control_bits));

    eil_check: assert property (@(posedge system_clk) disable iff (reset)
        eil_bar == exp_eil_bar)
        else value_mismatch("eil_bar", {10'b0, $sampled(exp_eil_bar)},
                            {10'b0, $sampled(eil_bar)});

    overflow_check: assert property (@(posedge system_clk) disable iff (reset)
        overflow == ref_overflow)
        else value_mismatch("overflow", {10'b0, $sampled(ref_overflow)},
                            {10'b0, $sampled(overflow)});

    always @(posedge system_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the test did not complete within %0d cycles", timeout_cycles);
            stop_with_failure();
        end
    end

    // Advance to 1 ns past the next edge with fresh status bits
    task automatic next_cycle();
        @(posedge system_clk);
        #1;
        rnd = $random(seed);
        status_bits = rnd[3:0];
    endtask

    task automatic push_opcode(input logic [3:0] op);
        opcode_in   = op;
        opcode_push = 1'b1;
        next_cycle();
        opcode_push = 1'b0;
    endtask

    task automatic wait_dispatch();
        do begin
            next_cycle();
        end while (eil_bar);
    endtask

    task automatic wait_address(input logic [7:0] addr);
        while (microaddress != addr) begin
            next_cycle();
        end
    endtask

    initial begin
        seed        = 94;
        reset       = 1'b1;
        opcode_in   = 4'h0;
        opcode_push = 1'b0;
        go_bar      = 1'b1;
        status_bits = 4'h0;
        jam         = 1'b0;
        repeat (16) @(posedge system_clk);
        #1;
        reset = 1'b0;

        // Idle spin, then wait for an opcode and dispatch it
        repeat (5) next_cycle();
        go_bar = 1'b0;
        repeat (4) next_cycle();
        push_opcode(4'h5);
        wait_dispatch();
        wait_address(8'h01);

        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            push_opcode(rnd[3:0]);
            wait_dispatch();
            wait_address(8'h01);
        end

        // Jam over a running routine, which then parks at idle
        push_opcode(4'h6);
        wait_dispatch();
        jam    = 1'b1;
        go_bar = 1'b1;
        repeat (3) next_cycle();
        jam = 1'b0;
        wait_address(8'h00);
        repeat (2) next_cycle();

        // Fifth push overflows, the four held opcodes dispatch in order
        push_opcode(4'h3);
        push_opcode(4'h7);
        push_opcode(4'hA);
        push_opcode(4'hC);
        push_opcode(4'hE);
        repeat (2) next_cycle();
        go_bar = 1'b0;
        repeat (4) wait_dispatch();
        wait_address(8'h01);
        repeat (3) next_cycle();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== control_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control section top: opcode queue, sequencer, control store
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module control_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        system_clk,
    input  logic        reset,
    input  logic [3:0]  opcode_in,
    input  logic        opcode_push,
    input  logic        go_bar,
    input  logic [3:0]  status_bits,
    input  logic        jam,
    output logic [7:0]  microaddress,
    output logic [10:0] control_bits,
    output logic        eil_bar,
    output logic        overflow
);

    logic [3:0]                     queue_head;
    logic                           not_empty;
    logic                           opcode_pop;
    logic [7:0]                     counter_address;
    logic [micro_pkg::mw_width-1:0] microword;

    opcode_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_opcode_queue (
        .system_clk  (system_clk),
        .reset       (reset),
        .opcode_in   (opcode_in),
        .opcode_push (opcode_push),
        .opcode_pop  (opcode_pop),
        .queue_head  (queue_head),
        .not_empty   (not_empty),
        .overflow    (overflow)
    );

    micro_sequencer u_micro_sequencer (
        .system_clk      (system_clk),
        .reset           (reset),
        .microword       (microword),
        .queue_head      (queue_head),
        .not_empty       (not_empty),
        .go_bar          (go_bar),
        .status_bits     (status_bits),
        .jam             (jam),
        .counter_address (counter_address),
        .microaddress    (microaddress),
        .control_bits    (control_bits),
        .eil_bar         (eil_bar),
        .opcode_pop      (opcode_pop)
    );

    // Addressed by the counter itself, not the jammed address
    control_store u_control_store (
        .address   (counter_address),
        .microword (microword)
    );

endmodule

// ==== micro_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microprogram sequencer: counter, condition branch, opcode
// dispatch and jam override of the microaddress
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module micro_sequencer (
    input  logic                                    system_clk,
    input  logic                                    reset,
    input  logic [micro_pkg::mw_width-1:0]          microword,
    input  logic [3:0]                              queue_head,
    input  logic                                    not_empty,
    input  logic                                    go_bar,
    input  logic [3:0]                              status_bits,
    input  logic                                    jam,
    output logic [7:0]                              counter_address,
    output logic [7:0]                              microaddress,
    output logic [micro_pkg::control_width-1:0]     control_bits,
    output logic                                    eil_bar,
    output logic                                    opcode_pop
);

    logic [3:0]                          addr_low;
    logic [3:0]                          addr_high;
    logic                                count_en;
    logic [3:0]                          bop;
    logic [micro_pkg::control_width-1:0] control_field;
    logic                                cond_out;
    logic                                load;
    logic                                dispatch;
    logic [7:0]                          load_target;
    logic [7:0]                          counter;

    // Microword fields
    assign addr_low      = microword[micro_pkg::addr_low_msb:micro_pkg::addr_low_lsb];
    assign addr_high     = microword[micro_pkg::addr_high_msb:micro_pkg::addr_high_lsb];
    assign count_en      = microword[micro_pkg::count_bit];
    assign bop           = microword[micro_pkg::bop_msb:micro_pkg::bop_lsb];
    assign control_field = microword[micro_pkg::control_msb:micro_pkg::control_lsb];

    // Condition multiplexer
    always_comb begin
        cond_out = 1'b0;
        case (bop[micro_pkg::bop_polarity_bit-1:0])
            micro_pkg::cond_status2:   cond_out = status_bits[2];
            micro_pkg::cond_not_empty: cond_out = not_empty;
            micro_pkg::cond_status0:   cond_out = status_bits[0];
            micro_pkg::cond_status1:   cond_out = status_bits[1];
            micro_pkg::cond_go_bar:    cond_out = go_bar;
            micro_pkg::cond_status3:   cond_out = status_bits[3];
            // Both tied low
            micro_pkg::cond_never,
            micro_pkg::cond_dispatch:  cond_out = 1'b0;
            default:                   cond_out = 1'b0;
        endcase
    end

    assign load     = cond_out ^ bop[micro_pkg::bop_polarity_bit];
    assign dispatch = (bop == micro_pkg::bop_dispatch);

    // Dispatch swaps the queued opcode into the high nibble
    assign load_target = {dispatch ? queue_head : addr_high, addr_low};

    always_ff @(posedge system_clk) begin
        if (reset) begin
            counter <= micro_pkg::entry_idle;
        end else if (load) begin
            counter <= load_target;
        end else if (count_en) begin
            counter <= counter + 8'd1;
        end
    end

    assign counter_address = counter;

    // Jam shows the all-ones address, whose ROM word is empty;
    // the counter underneath keeps running
    assign microaddress = jam ? micro_pkg::jam_address : counter;
    assign control_bits = jam ? '0 : control_field;

    assign opcode_pop = dispatch;
    assign eil_bar    = ~dispatch;

    // Microcode must test not_empty before it dispatches
    dispatch_has_opcode: assert property (@(posedge system_clk) disable iff (reset)
        dispatch |-> not_empty)
        else $error("micro_sequencer dispatched with an empty opcode queue");

    // First cycle out of reset starts at the idle entry
    reset_to_idle: assert property (@(posedge system_clk)
        $fell(reset) |-> (counter == micro_pkg::entry_idle))
        else $error("micro_sequencer counter not at entry_idle after reset");

endmodule

// ==== opcode_queue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode queue: circular FIFO of 4-bit opcodes, sticky overflow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module opcode_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       system_clk,
    input  logic       reset,
    input  logic [3:0] opcode_in,
    input  logic       opcode_push,
    input  logic       opcode_pop,
    output logic [3:0] queue_head,
    output logic       not_empty,
    output logic       overflow
);

    localparam int ptr_width   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int count_width = $clog2(QUEUE_DEPTH + 1);
    localparam logic [ptr_width-1:0]   last_slot = ptr_width'(QUEUE_DEPTH - 1);
    localparam logic [count_width-1:0] full_count = count_width'(QUEUE_DEPTH);

    logic [3:0]             slots [QUEUE_DEPTH];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   full;
    logic                   push_ok;
    logic                   pop_ok;

    assign full      = (count == full_count);
    assign not_empty = (count != '0);
    assign push_ok   = opcode_push && !full;
    assign pop_ok    = opcode_pop && not_empty;
    assign queue_head = slots[rd_ptr];

    // Storage is written only on an accepted push
    always_ff @(posedge system_clk) begin
        if (push_ok) begin
            slots[wr_ptr] <= opcode_in;
        end
    end

    always_ff @(posedge system_clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Dropped push, held until reset
            if (opcode_push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // The sequencer may only pop an opcode that is really there
    pop_not_empty: assert property (@(posedge system_clk) disable iff (reset)
        opcode_pop |-> not_empty)
        else $error("opcode_queue popped while empty");

endmodule

// ==== control_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control store: 256 x 24 microcode ROM, combinational read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module control_store (
    input  logic [7:0]                    address,
    output logic [micro_pkg::mw_width-1:0] microword
);

    // Low nibbles inside each opcode routine
    localparam logic [3:0] test_low = 4'h9;
    localparam logic [3:0] fail_low = 4'hA;
    localparam logic [3:0] pass_low = 4'hC;

    logic [3:0] op;

    // Assemble a branch operation from polarity and condition select
    function automatic logic [3:0] make_bop(input logic polarity, input logic [2:0] sel);
        make_bop = {polarity, sel};
    endfunction

    // Assemble one microword from its fields
    function automatic logic [micro_pkg::mw_width-1:0] make_word(
        input logic [micro_pkg::control_width-1:0] ctl,
        input logic [3:0]                          bop,
        input logic                                count,
        input logic [7:0]                          target
    );
        logic [micro_pkg::mw_width-1:0] w;
        w = '0;
        w[micro_pkg::control_msb:micro_pkg::control_lsb]     = ctl;
        w[micro_pkg::bop_msb:micro_pkg::bop_lsb]             = bop;
        w[micro_pkg::count_bit]                              = count;
        w[micro_pkg::addr_high_msb:micro_pkg::addr_high_lsb] = target[7:4];
        w[micro_pkg::addr_low_msb:micro_pkg::addr_low_lsb]   = target[3:0];
        return w;
    endfunction

    assign op = address[7:4];

    always_comb begin
        microword = '0;
        if (address == micro_pkg::entry_idle) begin
            // Spin here while go_bar is high
            microword = make_word('0, make_bop(1'b0, micro_pkg::cond_go_bar), 1'b1,
                                  micro_pkg::entry_idle);
        end else if (address == micro_pkg::entry_wait_op) begin
            // Wait for an opcode in the queue
            microword = make_word('0, make_bop(1'b1, micro_pkg::cond_not_empty), 1'b1,
                                  micro_pkg::entry_wait_op);
        end else if (address == micro_pkg::entry_dispatch) begin
            microword = make_word('0, micro_pkg::bop_dispatch, 1'b0,
                                  {4'h0, micro_pkg::routine_low});
        end else begin
            case (address[3:0])
                micro_pkg::routine_low: begin
                    microword = make_word({op, 7'b0000001}, micro_pkg::bop_next, 1'b1, 8'h00);
                end
                test_low: begin
                    // Status bit 2 set takes the pass branch
                    microword = make_word('0, make_bop(1'b0, micro_pkg::cond_status2), 1'b1,
                                          {op, pass_low});
                end
                fail_low: begin
                    microword = make_word({op, 7'b0000100}, micro_pkg::bop_jump, 1'b0,
                                          micro_pkg::entry_idle);
                end
                pass_low: begin
                    microword = make_word({op, 7'b0000010}, micro_pkg::bop_jump, 1'b0,
                                          micro_pkg::entry_idle);
                end
                default: begin
                    microword = '0;
                end
            endcase
        end
    end

endmodule

// ==== micro_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microcode definitions: microword fields, branch operations,
// condition select codes and microprogram entry addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package micro_pkg;

    // Microword layout
    localparam int mw_width      = 24;
    localparam int addr_low_lsb  = 0;
    localparam int addr_low_msb  = 3;
    localparam int addr_high_lsb = 4;
    localparam int addr_high_msb = 7;
    localparam int count_bit     = 8;
    localparam int bop_lsb       = 9;
    localparam int bop_msb       = 12;
    localparam int control_lsb   = 13;
    localparam int control_msb   = 23;
    localparam int control_width = control_msb - control_lsb + 1;

    // Top bit of the BOP field, XORed with the selected condition
    localparam int bop_polarity_bit = 3;

    // Condition select, in the order of the condition multiplexer inputs
    localparam logic [2:0] cond_status2   = 3'd0;
    localparam logic [2:0] cond_not_empty = 3'd1;
    localparam logic [2:0] cond_status0   = 3'd2;
    localparam logic [2:0] cond_status1   = 3'd3;
    localparam logic [2:0] cond_go_bar    = 3'd4;
    localparam logic [2:0] cond_status3   = 3'd5;
    localparam logic [2:0] cond_never     = 3'd6;
    localparam logic [2:0] cond_dispatch  = 3'd7;

    // Inverted constant zero, so the counter always loads
    localparam logic [3:0] bop_jump     = {1'b1, cond_never};
    // Loads with the queued opcode as high nibble
    localparam logic [3:0] bop_dispatch = {1'b1, cond_dispatch};
    // Never loads; count bit alone moves the counter
    localparam logic [3:0] bop_next     = {1'b0, cond_never};

    // Microprogram entry points
    localparam logic [7:0] entry_idle     = 8'h00;
    localparam logic [7:0] entry_wait_op  = 8'h01;
    localparam logic [7:0] entry_dispatch = 8'h02;
    localparam logic [7:0] jam_address    = 8'hFF;

    // Low nibble of every opcode routine entry
    localparam logic [3:0] routine_low = 4'h8;

endpackage
